// ==== flist.f ====
src/attr_bus_pkg.sv
src/attr_map_pkg.sv
src/attr_cell.sv
src/attr_access_port.sv
src/attr_write_arbiter.sv
src/slink_attr_bank.sv
tests/tb_clock_gen.sv
tests/slink_attr_bank_chk.sv
tests/slink_attr_bank_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f \
  --top-module slink_attr_bank_tb -o slink_attr_bank_sim
./obj_dir/slink_attr_bank_sim

// ==== tests/slink_attr_bank_tb.sv ====
`default_nettype none

module slink_attr_bank_tb;

  import attr_bus_pkg::*;
  import attr_map_pkg::*;

  localparam int TX_LANES_CLOG2 = 2;
  localparam int RX_LANES_CLOG2 = 2;
  localparam int RANDOM_CYCLES  = 4000;
  localparam int CHECK_TIMEOUT  = 20;

  logic           clk;
  logic           reset;
  logic           hard_reset_cond;
  logic           effective_update;
  // port order link, app, sw
  attr_addr_t     addr_in  [NUM_PORTS];
  attr_data_t     data_in  [NUM_PORTS];
  logic           upd_in   [NUM_PORTS];
  attr_data_t     read_out [NUM_PORTS];
  lane_cnt_t      eff_lane [4];
  hard_reset_us_t eff_hard_reset_us;
  clk_trail_t     eff_clk_trail;
  ts_len_t        eff_ts   [12];
  attr_data_t     eff_out  [NUM_ATTRS];
  attr_data_t     shadow_m    [NUM_ATTRS];
  attr_data_t     effective_m [NUM_ATTRS];
  logic [31:0]    rng;
  string          test_name;
  int             checks_done = 0;

  tb_clock_gen #(.PERIOD(10)) clock_i (.clk(clk));

  slink_attr_bank #(
    .NUM_TX_LANES_CLOG2 (TX_LANES_CLOG2),
    .NUM_RX_LANES_CLOG2 (RX_LANES_CLOG2)
  ) dut_i (
    .clk(clk), .reset(reset),
    .hard_reset_cond(hard_reset_cond), .effective_update(effective_update),
    .link_attr_addr(addr_in[0]), .link_attr_data(data_in[0]),
    .link_shadow_update(upd_in[0]), .link_attr_data_read(read_out[0]),
    .app_attr_addr(addr_in[1]), .app_attr_data(data_in[1]),
    .app_shadow_update(upd_in[1]), .app_attr_data_read(read_out[1]),
    .sw_attr_addr(addr_in[2]), .sw_attr_data(data_in[2]),
    .sw_shadow_update(upd_in[2]), .sw_attr_data_read(read_out[2]),
    .attr_max_txs(eff_lane[0]), .attr_max_rxs(eff_lane[1]),
    .attr_active_txs(eff_lane[2]), .attr_active_rxs(eff_lane[3]),
    .attr_hard_reset_us(eff_hard_reset_us), .attr_px_clk_trail(eff_clk_trail),
    .attr_p1_ts1_tx(eff_ts[0]), .attr_p1_ts1_rx(eff_ts[1]),
    .attr_p1_ts2_tx(eff_ts[2]), .attr_p1_ts2_rx(eff_ts[3]),
    .attr_p2_ts1_tx(eff_ts[4]), .attr_p2_ts1_rx(eff_ts[5]),
    .attr_p2_ts2_tx(eff_ts[6]), .attr_p2_ts2_rx(eff_ts[7]),
    .attr_p3r_ts1_tx(eff_ts[8]), .attr_p3r_ts1_rx(eff_ts[9]),
    .attr_p3r_ts2_tx(eff_ts[10]), .attr_p3r_ts2_rx(eff_ts[11])
  );

  bind slink_attr_bank slink_attr_bank_chk #(
    .NUM_TX_LANES_CLOG2 (NUM_TX_LANES_CLOG2),
    .NUM_RX_LANES_CLOG2 (NUM_RX_LANES_CLOG2)
  ) chk_i (
    .clk(clk), .reset(reset),
    .hard_reset_cond(hard_reset_cond), .effective_update(effective_update),
    .eff_all({attr_max_txs, attr_max_rxs, attr_active_txs, attr_active_rxs,
              attr_hard_reset_us, attr_px_clk_trail,
              attr_p1_ts1_tx, attr_p1_ts1_rx, attr_p1_ts2_tx, attr_p1_ts2_rx,
              attr_p2_ts1_tx, attr_p2_ts1_rx, attr_p2_ts2_tx, attr_p2_ts2_rx,
              attr_p3r_ts1_tx, attr_p3r_ts1_rx, attr_p3r_ts2_tx, attr_p3r_ts2_rx}),
    .addr_all({sw_attr_addr, app_attr_addr, link_attr_addr}),
    .read_all({sw_attr_data_read, app_attr_data_read, link_attr_data_read})
  );

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      eff_out[i] = attr_data_t'(eff_lane[i]);
    end
    eff_out[IDX_HARD_RESET_US] = attr_data_t'(eff_hard_reset_us);
    eff_out[IDX_PX_CLK_TRAIL]  = attr_data_t'(eff_clk_trail);
    for (int i = 0; i < 12; i++) begin
      eff_out[int'(IDX_P1_TS1_TX) + i] = eff_ts[i];
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic attr_data_t reset_word(int a);
    if (a == 0 || a == 2) return attr_data_t'(TX_LANES_CLOG2);
    if (a == 1 || a == 3) return attr_data_t'(RX_LANES_CLOG2);
    if (a == 4) return 16'd100;
    if (a == 5) return 16'd32;
    if (a < 10) return 16'd64;
    if (a < 14) return 16'd128;
    return 16'd32;
  endfunction

  // value bits kept by each attribute
  function automatic attr_data_t width_mask(int a);
    if (a < 4) return 16'h0007;
    if (a == 4) return 16'h03ff;
    if (a == 5) return 16'h00ff;
    return 16'hffff;
  endfunction

  // first port in link, app, sw order that writes the attribute wins
  function automatic attr_data_t next_shadow(int a);
    if (reset || hard_reset_cond) return reset_word(a);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (upd_in[p] && addr_in[p] == ATTR_ADDR[a]) return data_in[p] & width_mask(a);
    end
    return shadow_m[a];
  endfunction

  function automatic attr_data_t next_effective(int a);
    if (reset || hard_reset_cond) return reset_word(a);
    if (effective_update) return shadow_m[a];
    return effective_m[a];
  endfunction

  function automatic attr_data_t expected_read(attr_addr_t addr);
    for (int a = 0; a < NUM_ATTRS; a++) begin
      if (addr == ATTR_ADDR[a]) return shadow_m[a];
    end
    return '0;
  endfunction

  task automatic update_model();
    attr_data_t sh [NUM_ATTRS];
    attr_data_t ef [NUM_ATTRS];
    for (int a = 0; a < NUM_ATTRS; a++) begin
      sh[a] = next_shadow(a);
      ef[a] = next_effective(a);
    end
    shadow_m    = sh;
    effective_m = ef;
  endtask

  task automatic check_word(string what, attr_data_t exp, attr_data_t got);
    assert (got === exp) else begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, got);
      $display("Verification failed");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_reset_values();
    for (int a = 0; a < NUM_ATTRS; a++) begin
      check_word($sformatf("reset value of attribute %0d", a), reset_word(a), eff_out[a]);
    end
  endtask

  // strobes last one cycle unless driven again
  task automatic next_cycle();
    @(posedge clk);
    #1;
    effective_update = 1'b0;
    hard_reset_cond  = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      upd_in[p] = 1'b0;
    end
  endtask

  task automatic write_attr(int p, attr_addr_t addr, attr_data_t data);
    addr_in[p] = addr;
    data_in[p] = data;
    upd_in[p]  = 1'b1;
  endtask

  task automatic wait_for_checks(int target);
    int waited;
    waited = 0;
    while (checks_done < target) begin
      if (waited >= CHECK_TIMEOUT) begin
        $display("timeout: the compare process stopped checking the outputs");
        $display("Verification failed");
        $fatal(1, "timeout");
      end
      @(posedge clk);
      waited++;
    end
  endtask

  // model steps on the inputs held over the last cycle, outputs checked mid-cycle
  initial begin : compare_outputs
    forever begin
      @(posedge clk);
      update_model();
      @(negedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
        check_word($sformatf("read port %0d", p), expected_read(addr_in[p]), read_out[p]);
      end
      for (int a = 0; a < NUM_ATTRS; a++) begin
        check_word($sformatf("effective %0d", a), effective_m[a], eff_out[a]);
      end
      checks_done++;
    end
  end

  initial begin : stimulus
    int target;
    reset            = 1'b1;
    hard_reset_cond  = 1'b0;
    effective_update = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      addr_in[p] = '0;
      data_in[p] = '0;
      upd_in[p]  = 1'b0;
    end
    rng       = 32'd1542;
    test_name = "reset";
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int a = 0; a < NUM_ATTRS; a++) begin
      next_cycle();
      addr_in[a % NUM_PORTS] = ATTR_ADDR[a];
    end
    @(negedge clk);
    check_reset_values();

    test_name = "port_write";
    for (int p = 0; p < NUM_PORTS; p++) begin
      next_cycle();
      write_attr(p, ATTR_ADDR[int'(IDX_P1_TS1_TX) + p], attr_data_t'(16'h1230 + p));
      next_cycle();
      for (int q = 0; q < NUM_PORTS; q++) begin
        addr_in[q] = ATTR_ADDR[int'(IDX_P1_TS1_TX) + p];
      end
    end
    next_cycle();
    effective_update = 1'b1;
    next_cycle();

    test_name = "priority";
    for (int p = 0; p < NUM_PORTS; p++) begin
      write_attr(p, ATTR_ADDR[IDX_P2_TS1_TX], attr_data_t'(16'ha000 + p));
    end
    next_cycle();
    write_attr(1, ATTR_ADDR[IDX_P2_TS2_RX], 16'hb001);
    write_attr(2, ATTR_ADDR[IDX_P2_TS2_RX], 16'hb002);
    @(negedge clk);
    check_word("link wins", 16'ha000, read_out[0]);
    next_cycle();
    check_word("app wins", 16'hb001, read_out[1]);
    write_attr(0, ATTR_ADDR[IDX_ACTIVE_TXS], 16'h0005);
    write_attr(1, ATTR_ADDR[IDX_P2_TS1_RX], 16'hc001);
    write_attr(2, ATTR_ADDR[IDX_P3R_TS1_TX], 16'hc002);
    next_cycle();
    effective_update = 1'b1;

    test_name = "truncate";
    next_cycle();
    write_attr(0, ATTR_ADDR[IDX_MAX_RXS], 16'hffff);
    write_attr(1, ATTR_ADDR[IDX_HARD_RESET_US], 16'hffff);
    write_attr(2, ATTR_ADDR[IDX_PX_CLK_TRAIL], 16'hffff);
    next_cycle();
    @(negedge clk);
    check_word("3-bit read", 16'h0007, read_out[0]);
    check_word("8-bit read", 16'h00ff, read_out[2]);
    next_cycle();
    write_attr(2, 16'h0004, 16'hbeef);
    next_cycle();
    @(negedge clk);
    check_word("unmapped read", 16'h0000, read_out[2]);
    check_word("10-bit read", 16'h03ff, read_out[1]);
    next_cycle();
    effective_update = 1'b1;

    test_name = "hard_reset";
    next_cycle();
    write_attr(0, ATTR_ADDR[IDX_P3R_TS2_RX], 16'h5555);
    effective_update = 1'b1;
    hard_reset_cond  = 1'b1;
    next_cycle();
    @(negedge clk);
    check_reset_values();
    // sweep every shadow through the read ports
    for (int a = 0; a < NUM_ATTRS; a++) begin
      next_cycle();
      addr_in[a % NUM_PORTS] = ATTR_ADDR[a];
    end

    test_name = "random";
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      next_cycle();
      for (int p = 0; p < NUM_PORTS; p++) begin
        rng = xorshift(rng);
        if (rng[3:0] == 4'd0) begin
          addr_in[p] = 16'h1000 | attr_addr_t'(rng[15:4]);
        end else begin
          addr_in[p] = ATTR_ADDR[int'(rng[20:16]) % NUM_ATTRS];
        end
        upd_in[p] = rng[8];
        rng = xorshift(rng);
        data_in[p] = rng[15:0];
      end
      rng = xorshift(rng);
      effective_update = (rng[2:0] == 3'd0);
      hard_reset_cond  = (rng[10:5] == 6'd0);
    end

    test_name = "drain";
    target = checks_done + 3;
    next_cycle();
    wait_for_checks(target);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/slink_attr_bank_chk.sv ====
`default_nettype none

module slink_attr_bank_chk #(
  parameter int NUM_TX_LANES_CLOG2 = 2,
  parameter int NUM_RX_LANES_CLOG2 = 2
) (
  input wire         clk,
  input wire         reset,
  input wire         hard_reset_cond,
  input wire         effective_update,
  // all effective outputs, max_txs in the top bits
  input wire [221:0] eff_all,
  // link in the low word, sw in the high word
  input wire [47:0]  addr_all,
  input wire [47:0]  read_all
);

  import attr_map_pkg::*;

  localparam logic [221:0] RESET_ALL = {
    lane_cnt_t'(NUM_TX_LANES_CLOG2), lane_cnt_t'(NUM_RX_LANES_CLOG2),
    lane_cnt_t'(NUM_TX_LANES_CLOG2), lane_cnt_t'(NUM_RX_LANES_CLOG2),
    10'd100, 8'd32, {4{16'd64}}, {4{16'd128}}, {4{16'd32}}
  };

  function automatic logic is_mapped(logic [15:0] addr);
    for (int a = 0; a < NUM_ATTRS; a++) begin
      if (addr == ATTR_ADDR[a]) return 1'b1;
    end
    return 1'b0;
  endfunction

  // effective copies only move on an update or a hard reset
  effective_hold_a : assert property (@(posedge clk) disable iff (reset)
    !$stable(eff_all) |-> ($past(effective_update) || $past(hard_reset_cond)))
    else $error("effective output changed without effective_update or hard_reset_cond");

  hard_reset_values_a : assert property (@(posedge clk) disable iff (reset)
    hard_reset_cond |=> (eff_all == RESET_ALL))
    else $error("effective outputs not at reset values after hard_reset_cond");

  for (genvar p = 0; p < 3; p++) begin : g_unmapped
    unmapped_read_a : assert property (@(posedge clk) disable iff (reset)
      !is_mapped(addr_all[16*p +: 16]) |-> (read_all[16*p +: 16] == 16'h0000))
      else $error("unmapped address on read port %0d did not read zero", p);
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== src/slink_attr_bank.sv ====
`default_nettype none

module slink_attr_bank #(
  parameter int NUM_TX_LANES_CLOG2 = 2,
  parameter int NUM_RX_LANES_CLOG2 = 2
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          hard_reset_cond,
  input  wire                          effective_update,

  input  attr_bus_pkg::attr_addr_t     link_attr_addr,
  input  attr_bus_pkg::attr_data_t     link_attr_data,
  input  wire                          link_shadow_update,
  output attr_bus_pkg::attr_data_t     link_attr_data_read,

  input  attr_bus_pkg::attr_addr_t     app_attr_addr,
  input  attr_bus_pkg::attr_data_t     app_attr_data,
  input  wire                          app_shadow_update,
  output attr_bus_pkg::attr_data_t     app_attr_data_read,

  input  attr_bus_pkg::attr_addr_t     sw_attr_addr,
  input  attr_bus_pkg::attr_data_t     sw_attr_data,
  input  wire                          sw_shadow_update,
  output attr_bus_pkg::attr_data_t     sw_attr_data_read,

  output attr_map_pkg::lane_cnt_t      attr_max_txs,
  output attr_map_pkg::lane_cnt_t      attr_max_rxs,
  output attr_map_pkg::lane_cnt_t      attr_active_txs,
  output attr_map_pkg::lane_cnt_t      attr_active_rxs,
  output attr_map_pkg::hard_reset_us_t attr_hard_reset_us,
  output attr_map_pkg::clk_trail_t     attr_px_clk_trail,
  output attr_map_pkg::ts_len_t        attr_p1_ts1_tx,
  output attr_map_pkg::ts_len_t        attr_p1_ts1_rx,
  output attr_map_pkg::ts_len_t        attr_p1_ts2_tx,
  output attr_map_pkg::ts_len_t        attr_p1_ts2_rx,
  output attr_map_pkg::ts_len_t        attr_p2_ts1_tx,
  output attr_map_pkg::ts_len_t        attr_p2_ts1_rx,
  output attr_map_pkg::ts_len_t        attr_p2_ts2_tx,
  output attr_map_pkg::ts_len_t        attr_p2_ts2_rx,
  output attr_map_pkg::ts_len_t        attr_p3r_ts1_tx,
  output attr_map_pkg::ts_len_t        attr_p3r_ts1_rx,
  output attr_map_pkg::ts_len_t        attr_p3r_ts2_tx,
  output attr_map_pkg::ts_len_t        attr_p3r_ts2_rx
);

  import attr_bus_pkg::*;
  import attr_map_pkg::*;

  localparam int NUM_TS = NUM_ATTRS - IDX_P1_TS1_TX;

  attr_sel_t        port_sel  [NUM_PORTS];
  attr_data_t       port_data [NUM_PORTS];
  attr_sel_t        wr_en;
  attr_word_array_t wr_data;
  attr_word_array_t shadow_words;

  lane_cnt_t        max_txs_shadow;
  lane_cnt_t        max_rxs_shadow;
  lane_cnt_t        active_txs_shadow;
  lane_cnt_t        active_rxs_shadow;
  hard_reset_us_t   hard_reset_us_shadow;
  clk_trail_t       px_clk_trail_shadow;
  ts_len_t          ts_effective [NUM_TS];

  attr_access_port link_port_i (
    .attr_addr      (link_attr_addr),
    .attr_data      (link_attr_data),
    .shadow_update  (link_shadow_update),
    .shadow_words   (shadow_words),
    .write_sel      (port_sel[REQ_LINK]),
    .attr_data_read (link_attr_data_read),
    .write_data     (port_data[REQ_LINK])
  );

  attr_access_port app_port_i (
    .attr_addr      (app_attr_addr),
    .attr_data      (app_attr_data),
    .shadow_update  (app_shadow_update),
    .shadow_words   (shadow_words),
    .write_sel      (port_sel[REQ_APP]),
    .attr_data_read (app_attr_data_read),
    .write_data     (port_data[REQ_APP])
  );

  attr_access_port sw_port_i (
    .attr_addr      (sw_attr_addr),
    .attr_data      (sw_attr_data),
    .shadow_update  (sw_shadow_update),
    .shadow_words   (shadow_words),
    .write_sel      (port_sel[REQ_SW]),
    .attr_data_read (sw_attr_data_read),
    .write_data     (port_data[REQ_SW])
  );

  attr_write_arbiter arbiter_i (
    .port_sel  (port_sel),
    .port_data (port_data),
    .wr_en     (wr_en),
    .wr_data   (wr_data)
  );

  // lane counts reset to the configured lane widths
  attr_cell #(.value_t(lane_cnt_t), .RESET_VAL(lane_cnt_t'(NUM_TX_LANES_CLOG2))) max_txs_i (
    .clk(clk), .reset(reset), .hard_reset_cond(hard_reset_cond),
    .wr_en(wr_en[IDX_MAX_TXS]), .wr_data(wr_data[IDX_MAX_TXS]),
    .effective_update(effective_update),
    .shadow(max_txs_shadow), .effective(attr_max_txs)
  );

  attr_cell #(.value_t(lane_cnt_t), .RESET_VAL(lane_cnt_t'(NUM_RX_LANES_CLOG2))) max_rxs_i (
    .clk(clk), .reset(reset), .hard_reset_cond(hard_reset_cond),
    .wr_en(wr_en[IDX_MAX_RXS]), .wr_data(wr_data[IDX_MAX_RXS]),
    .effective_update(effective_update),
    .shadow(max_rxs_shadow), .effective(attr_max_rxs)
  );

  attr_cell #(.value_t(lane_cnt_t), .RESET_VAL(lane_cnt_t'(NUM_TX_LANES_CLOG2))) active_txs_i (
    .clk(clk), .reset(reset), .hard_reset_cond(hard_reset_cond),
    .wr_en(wr_en[IDX_ACTIVE_TXS]), .wr_data(wr_data[IDX_ACTIVE_TXS]),
    .effective_update(effective_update),
    .shadow(active_txs_shadow), .effective(attr_active_txs)
  );

  attr_cell #(.value_t(lane_cnt_t), .RESET_VAL(lane_cnt_t'(NUM_RX_LANES_CLOG2))) active_rxs_i (
    .clk(clk), .reset(reset), .hard_reset_cond(hard_reset_cond),
    .wr_en(wr_en[IDX_ACTIVE_RXS]), .wr_data(wr_data[IDX_ACTIVE_RXS]),
    .effective_update(effective_update),
    .shadow(active_rxs_shadow), .effective(attr_active_rxs)
  );

  attr_cell #(
    .value_t   (hard_reset_us_t),
    .RESET_VAL (hard_reset_us_t'(ATTR_RESET[IDX_HARD_RESET_US]))
  ) hard_reset_us_i (
    .clk(clk), .reset(reset), .hard_reset_cond(hard_reset_cond),
    .wr_en(wr_en[IDX_HARD_RESET_US]), .wr_data(wr_data[IDX_HARD_RESET_US]),
    .effective_update(effective_update),
    .shadow(hard_reset_us_shadow), .effective(attr_hard_reset_us)
  );

  attr_cell #(
    .value_t   (clk_trail_t),
    .RESET_VAL (clk_trail_t'(ATTR_RESET[IDX_PX_CLK_TRAIL]))
  ) px_clk_trail_i (
    .clk(clk), .reset(reset), .hard_reset_cond(hard_reset_cond),
    .wr_en(wr_en[IDX_PX_CLK_TRAIL]), .wr_data(wr_data[IDX_PX_CLK_TRAIL]),
    .effective_update(effective_update),
    .shadow(px_clk_trail_shadow), .effective(attr_px_clk_trail)
  );

  // zero-extend narrow shadows for read-back
  assign shadow_words[IDX_MAX_TXS]       = attr_data_t'(max_txs_shadow);
  assign shadow_words[IDX_MAX_RXS]       = attr_data_t'(max_rxs_shadow);
  assign shadow_words[IDX_ACTIVE_TXS]    = attr_data_t'(active_txs_shadow);
  assign shadow_words[IDX_ACTIVE_RXS]    = attr_data_t'(active_rxs_shadow);
  assign shadow_words[IDX_HARD_RESET_US] = attr_data_t'(hard_reset_us_shadow);
  assign shadow_words[IDX_PX_CLK_TRAIL]  = attr_data_t'(px_clk_trail_shadow);

  // training-sequence lengths, one cell per map index
  for (genvar i = IDX_P1_TS1_TX; i < NUM_ATTRS; i++) begin : g_ts
    ts_len_t ts_shadow;

    attr_cell #(.value_t(ts_len_t), .RESET_VAL(ts_len_t'(ATTR_RESET[i]))) ts_i (
      .clk(clk), .reset(reset), .hard_reset_cond(hard_reset_cond),
      .wr_en(wr_en[i]), .wr_data(wr_data[i]),
      .effective_update(effective_update),
      .shadow(ts_shadow), .effective(ts_effective[i - IDX_P1_TS1_TX])
    );

    assign shadow_words[i] = attr_data_t'(ts_shadow);
  end

  assign attr_p1_ts1_tx  = ts_effective[0];
  assign attr_p1_ts1_rx  = ts_effective[1];
  assign attr_p1_ts2_tx  = ts_effective[2];
  assign attr_p1_ts2_rx  = ts_effective[3];
  assign attr_p2_ts1_tx  = ts_effective[4];
  assign attr_p2_ts1_rx  = ts_effective[5];
  assign attr_p2_ts2_tx  = ts_effective[6];
  assign attr_p2_ts2_rx  = ts_effective[7];
  assign attr_p3r_ts1_tx = ts_effective[8];
  assign attr_p3r_ts1_rx = ts_effective[9];
  assign attr_p3r_ts2_tx = ts_effective[10];
  assign attr_p3r_ts2_rx = ts_effective[11];

endmodule

`default_nettype wire

// ==== src/attr_write_arbiter.sv ====
`default_nettype none

module attr_write_arbiter (
  input  attr_map_pkg::attr_sel_t        port_sel  [attr_bus_pkg::NUM_PORTS],
  input  attr_bus_pkg::attr_data_t       port_data [attr_bus_pkg::NUM_PORTS],
  output attr_map_pkg::attr_sel_t        wr_en,
  output attr_map_pkg::attr_word_array_t wr_data
);

  import attr_bus_pkg::*;
  import attr_map_pkg::*;

  // per attribute, so writes to different attributes never block each other
  always_comb begin
    for (int a = 0; a < NUM_ATTRS; a++) begin
      wr_en[a]   = 1'b0;
      wr_data[a] = '0;
      // scan lowest priority first, the last hit wins
      for (int p = NUM_PORTS - 1; p >= 0; p--) begin
        if (port_sel[p][a]) begin
          wr_en[a]   = 1'b1;
          wr_data[a] = port_data[p];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/attr_access_port.sv ====
`default_nettype none

module attr_access_port (
  input  attr_bus_pkg::attr_addr_t       attr_addr,
  input  attr_bus_pkg::attr_data_t       attr_data,
  input  wire                            shadow_update,
  input  attr_map_pkg::attr_word_array_t shadow_words,
  output attr_map_pkg::attr_sel_t        write_sel,
  output attr_bus_pkg::attr_data_t       attr_data_read,
  output attr_bus_pkg::attr_data_t       write_data
);

  import attr_bus_pkg::*;
  import attr_map_pkg::*;

  logic      hit;
  attr_idx_t idx;

  // address decode against the attribute map
  always_comb begin
    hit = 1'b0;
    idx = '0;
    for (int a = 0; a < NUM_ATTRS; a++) begin
      if (attr_addr == ATTR_ADDR[a]) begin
        hit = 1'b1;
        idx = attr_idx_t'(a);
      end
    end
  end

  // one-hot select, only while the strobe is up
  always_comb begin
    write_sel = '0;
    if (shadow_update && hit) begin
      write_sel[idx] = 1'b1;
    end
  end

  assign write_data = attr_data;

  // unmapped addresses read as zero
  always_comb begin
    if (hit) begin
      attr_data_read = shadow_words[idx];
    end else begin
      attr_data_read = '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/attr_cell.sv ====
`default_nettype none

module attr_cell #(
  parameter type    value_t   = logic [15:0],
  parameter value_t RESET_VAL = '0
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      hard_reset_cond,
  input  wire                      wr_en,
  input  attr_bus_pkg::attr_data_t wr_data,
  input  wire                      effective_update,
  output value_t                   shadow,
  output value_t                   effective
);

  // hard reset wins over write and effective update
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      shadow    <= RESET_VAL;
      effective <= RESET_VAL;
    end else if (hard_reset_cond) begin
      shadow    <= RESET_VAL;
      effective <= RESET_VAL;
    end else begin
      // upper bits of the bus word are dropped
      if (wr_en) begin
        shadow <= value_t'(wr_data);
      end
      // takes the shadow value from before this edge
      if (effective_update) begin
        effective <= shadow;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/attr_map_pkg.sv ====
`default_nettype none

package attr_map_pkg;

  localparam int NUM_ATTRS = 18;

  typedef logic [4:0] attr_idx_t;
  typedef logic [NUM_ATTRS-1:0] attr_sel_t;
  typedef attr_bus_pkg::attr_data_t attr_word_array_t [NUM_ATTRS];

  // attribute value types
  typedef logic [2:0]  lane_cnt_t;
  typedef logic [9:0]  hard_reset_us_t;
  typedef logic [7:0]  clk_trail_t;
  typedef logic [15:0] ts_len_t;

  localparam attr_idx_t IDX_MAX_TXS       = 5'd0;
  localparam attr_idx_t IDX_MAX_RXS       = 5'd1;
  localparam attr_idx_t IDX_ACTIVE_TXS    = 5'd2;
  localparam attr_idx_t IDX_ACTIVE_RXS    = 5'd3;
  localparam attr_idx_t IDX_HARD_RESET_US = 5'd4;
  localparam attr_idx_t IDX_PX_CLK_TRAIL  = 5'd5;
  // training lengths are contiguous from here to the end
  localparam attr_idx_t IDX_P1_TS1_TX     = 5'd6;
  localparam attr_idx_t IDX_P1_TS1_RX     = 5'd7;
  localparam attr_idx_t IDX_P1_TS2_TX     = 5'd8;
  localparam attr_idx_t IDX_P1_TS2_RX     = 5'd9;
  localparam attr_idx_t IDX_P2_TS1_TX     = 5'd10;
  localparam attr_idx_t IDX_P2_TS1_RX     = 5'd11;
  localparam attr_idx_t IDX_P2_TS2_TX     = 5'd12;
  localparam attr_idx_t IDX_P2_TS2_RX     = 5'd13;
  localparam attr_idx_t IDX_P3R_TS1_TX    = 5'd14;
  localparam attr_idx_t IDX_P3R_TS1_RX    = 5'd15;
  localparam attr_idx_t IDX_P3R_TS2_TX    = 5'd16;
  localparam attr_idx_t IDX_P3R_TS2_RX    = 5'd17;

  // access port address of each attribute, by index
  localparam attr_bus_pkg::attr_addr_t ATTR_ADDR [NUM_ATTRS] = '{
    16'h0000, 16'h0001, 16'h0002, 16'h0003,
    16'h0008, 16'h0010,
    16'h0020, 16'h0021, 16'h0022, 16'h0023,
    16'h0024, 16'h0025, 16'h0026, 16'h0027,
    16'h0028, 16'h0029, 16'h002a, 16'h002b
  };

  // lane count entries are placeholders, the real values are top parameters
  localparam attr_word_array_t ATTR_RESET = '{
    16'd0,   16'd0,   16'd0,   16'd0,
    16'd100, 16'd32,
    16'd64,  16'd64,  16'd64,  16'd64,
    16'd128, 16'd128, 16'd128, 16'd128,
    16'd32,  16'd32,  16'd32,  16'd32
  };

endpackage

`default_nettype wire

// ==== src/attr_bus_pkg.sv ====
`default_nettype none

package attr_bus_pkg;

  // address and data seen on every access port
  typedef logic [15:0] attr_addr_t;
  typedef logic [15:0] attr_data_t;

  localparam int NUM_PORTS = 3;

  // declaration order is the write priority, link first
  typedef enum logic [1:0] {
    REQ_LINK,
    REQ_APP,
    REQ_SW
  } requester_e;

endpackage

`default_nettype wire
